/* periph_hub.f */
+incdir+.
periph_pkg.sv
periph_read_resp.sv
periph_bus_decode.sv
gpio_regs.sv
pin_func_mux.sv
periph_hub.sv
tb_periph_hub.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 -f periph_hub.f \
    --top-module tb_periph_hub -o tb_periph_hub &&
./obj_dir/tb_periph_hub ||
{ echo "Simulation run ended with an error"; exit 1; }

/* tb_periph_hub.sv */
/*
 * Self-checking testbench of the peripheral bus fabric. Random external
 * slot models sit on the slot arrays, and a table of bus operations is
 * applied to the DUT and checked against expected values.
 */
`timescale 1ns/1ps
`default_nettype none
`include "periph_defines.svh"

module tb_periph_hub;

    localparam int READ_TIMEOUT = 50;
    localparam int SLOT0_WAIT   = 20;

    typedef enum logic [1:0] {
        OP_WR,
        OP_RD,
        OP_NORESP,
        OP_PIN
    } op_kind_e;

    typedef struct packed {
        op_kind_e          kind;
        periph_pkg::addr_t addr;
        periph_pkg::word_t data;
        periph_pkg::word_t expected;
        logic [7:0]        delay;
    } op_t;

    logic                    clk;
    logic                    rst_n;
    periph_pkg::byte_t       ui_in;
    periph_pkg::addr_t       addr;
    periph_pkg::word_t       wdata;
    periph_pkg::access_e     write_n;
    periph_pkg::access_e     read_n;
    logic                    read_complete;
    periph_pkg::user_rsp_t   user_rsp [`PERI_SLOTS];
    periph_pkg::simple_rsp_t simple_rsp [`PERI_SLOTS];
    periph_pkg::user_req_t   user_req [`PERI_SLOTS];
    logic [`PERI_SLOTS-1:0]  simple_wr;
    periph_pkg::word_t       data_out;
    logic                    data_ready;
    periph_pkg::byte_t       uo_out;
    op_t                     ops [$];

    periph_hub UUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .i_addr               (addr),
        .i_data               (wdata),
        .i_data_write_n       (write_n),
        .i_data_read_n        (read_n),
        .i_data_read_complete (read_complete),
        .i_user_rsp           (user_rsp),
        .i_simple_rsp         (simple_rsp),
        .o_user_req           (user_req),
        .o_simple_wr          (simple_wr),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .o_uo_out             (uo_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    function automatic periph_pkg::addr_t user_addr(input int slot, input int ofs);
        return {1'b0, 4'(slot), 6'(ofs)};
    endfunction

    function automatic periph_pkg::addr_t simple_addr(input int slot);
        return {1'b1, 2'b00, 4'(slot), 4'h0};
    endfunction

    task automatic add_op(input op_kind_e kind, input periph_pkg::addr_t op_addr,
                          input periph_pkg::word_t data, input periph_pkg::word_t expected,
                          input int delay);
        op_t op;

        op.kind     = kind;
        op.addr     = op_addr;
        op.data     = data;
        op.expected = expected;
        op.delay    = 8'(delay);
        ops.push_back(op);
    endtask

    task automatic build_table();
        periph_pkg::byte_t gpio_val;
        periph_pkg::byte_t route;

        gpio_val = 8'hA5;

        // Reset values of the GPIO output, the selects and the pins
        add_op(OP_RD, user_addr(1, int'(`GPIO_OUT_OFS)), 32'h0, 32'h0, 0);
        for (int p = 0; p < `PERI_PINS; p++) begin
            add_op(OP_RD, user_addr(1, 'h20 + 4 * p), 32'h0, (p < 2) ? 2 : 1, 0);
        end
        add_op(OP_PIN, '0, 32'h0, {30'h0, user_rsp[2].pins[1:0]}, 0);

        // GPIO output, input readback and unmapped offsets
        add_op(OP_WR, user_addr(1, int'(`GPIO_OUT_OFS)), 32'hC0DE_77A5, 32'h0, 0);
        add_op(OP_RD, user_addr(1, int'(`GPIO_OUT_OFS)), 32'h0, {24'h0, gpio_val}, 0);
        add_op(OP_PIN, '0, 32'h0, {24'h0, gpio_val[7:2], user_rsp[2].pins[1:0]}, 0);
        add_op(OP_RD, user_addr(1, int'(`GPIO_IN_OFS)), 32'h0, {24'h0, ui_in}, 0);
        add_op(OP_RD, user_addr(1, 'h08), 32'h0, 32'h0, 0);
        add_op(OP_RD, user_addr(1, 'h18), 32'h0, 32'h0, 0);
        add_op(OP_RD, user_addr(1, 'h26), 32'h0, 32'h0, 0);

        // Decode of external user and simple slots
        add_op(OP_WR, user_addr(6, 'h10), 32'h0BAD_F00D, 32'h0, 0);
        add_op(OP_WR, user_addr(14, 'h3C), 32'h1357_9BDF, 32'h0, 0);
        add_op(OP_WR, simple_addr(9), 32'h0000_0042, 32'h0, 0);
        add_op(OP_WR, simple_addr(0), 32'h0000_0024, 32'h0, 0);
        add_op(OP_RD, user_addr(3, 'h00), 32'h0, user_rsp[3].data, 0);
        add_op(OP_RD, user_addr(12, 'h2C), 32'h0, user_rsp[12].data, 0);
        add_op(OP_RD, simple_addr(7), 32'h0, {24'h0, simple_rsp[7].data}, 0);
        add_op(OP_RD, simple_addr(15), 32'h0, {24'h0, simple_rsp[15].data}, 0);
        add_op(OP_NORESP, user_addr(0, 'h00), 32'h0, 32'h0, 0);

        // Slow slots hold the read until their ready rises
        add_op(OP_RD, user_addr(5, 'h04), 32'h0, user_rsp[5].data, 6);
        add_op(OP_RD, user_addr(11, 'h30), 32'h0, user_rsp[11].data, 2);

        // Pin routing with junk upper data bits that the selects ignore
        add_op(OP_WR, user_addr(1, 'h20), 32'hFFFF_FFF3, 32'h0, 0);
        add_op(OP_WR, user_addr(1, 'h24), 32'hFFFF_FFE4, 32'h0, 0);
        add_op(OP_WR, user_addr(1, 'h28), 32'hFFFF_FFFF, 32'h0, 0);
        add_op(OP_WR, user_addr(1, 'h2C), 32'hFFFF_FFE9, 32'h0, 0);
        add_op(OP_WR, user_addr(1, 'h30), 32'hFFFF_FFE1, 32'h0, 0);
        add_op(OP_WR, user_addr(1, 'h34), 32'hFFFF_FFE0, 32'h0, 0);
        add_op(OP_WR, user_addr(1, 'h38), 32'hFFFF_FFF0, 32'h0, 0);
        add_op(OP_WR, user_addr(1, 'h3C), 32'hFFFF_FFEF, 32'h0, 0);
        add_op(OP_RD, user_addr(1, 'h28), 32'h0, 32'h1F, 0);
        add_op(OP_RD, user_addr(1, 'h2C), 32'h0, 32'h09, 0);
        route = {user_rsp[15].pins[7], simple_rsp[0].pins[6], 1'b0, gpio_val[4],
                 user_rsp[9].pins[3], simple_rsp[15].pins[2], user_rsp[4].pins[1],
                 simple_rsp[3].pins[0]};
        add_op(OP_PIN, '0, 32'h0, {24'h0, route}, 0);
    endtask

    task automatic run_write(input op_t op);
        logic                is_simple;
        periph_pkg::slot_t   sel;
        periph_pkg::access_e exp_wr;

        is_simple = op.addr[`PERI_SIMPLE_BIT];
        sel       = is_simple ? op.addr[7:4] : op.addr[9:6];
        addr      = op.addr;
        wdata     = op.data;
        write_n   = periph_pkg::ACC_WORD;
        #1;
        check_val("o_data_ready", 32'(data_ready), 32'h1);
        for (int s = 0; s < `PERI_SLOTS; s++) begin
            exp_wr = (!is_simple && sel == 4'(s)) ? periph_pkg::ACC_WORD : periph_pkg::ACC_NONE;
            check_val($sformatf("o_user_req[%0d].write_n", s), 32'(user_req[s].write_n),
                      32'(exp_wr));
        end
        check_val("o_simple_wr", 32'(simple_wr), is_simple ? 32'(16'h1 << sel) : 32'h0);
        @(negedge clk);
        write_n = periph_pkg::ACC_NONE;
    endtask

    task automatic run_read(input op_t op);
        logic              is_simple;
        logic              is_external;
        periph_pkg::slot_t sel;
        int                cnt;

        is_simple   = op.addr[`PERI_SIMPLE_BIT];
        sel         = is_simple ? op.addr[7:4] : op.addr[9:6];
        is_external = !is_simple && (sel > 4'd1);
        if (is_external && op.delay != 8'd0) begin
            user_rsp[sel].ready = 1'b0;
        end
        addr   = op.addr;
        read_n = periph_pkg::ACC_WORD;
        #1;
        if (!is_simple) begin
            check_val("o_user_req.read_n", 32'(user_req[sel].read_n), 32'(periph_pkg::ACC_WORD));
        end

        // Nothing completes while the slow slot is not ready
        if (is_external) begin
            for (int i = 0; i < int'(op.delay); i++) begin
                @(negedge clk);
                check_val("o_data_ready", 32'(data_ready), 32'h0);
            end
            user_rsp[sel].ready = 1'b1;
        end

        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!data_ready && cnt < READ_TIMEOUT);
        if (!data_ready) begin
            fail_run($sformatf("Timeout waiting for o_data_ready on read of address 0x%03h",
                               op.addr));
        end
        check_val("o_data_out", data_out, op.expected);
        if (!is_simple) begin
            check_val("o_user_req.read_n", 32'(user_req[sel].read_n), 32'(periph_pkg::ACC_NONE));
        end

        // Held data must ignore a slot that changes its mind
        if (is_external) begin
            user_rsp[sel].data = ~user_rsp[sel].data;
            @(negedge clk);
            check_val("o_data_out", data_out, op.expected);
            check_val("o_data_ready", 32'(data_ready), 32'h1);
            user_rsp[sel].data = ~user_rsp[sel].data;
        end

        read_complete = 1'b1;
        read_n        = periph_pkg::ACC_NONE;
        @(negedge clk);
        read_complete = 1'b0;
        check_val("o_data_ready", 32'(data_ready), 32'h0);
    endtask

    task automatic run_noresp(input op_t op);
        int cnt;

        addr   = op.addr;
        read_n = periph_pkg::ACC_WORD;
        cnt    = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!data_ready && cnt < SLOT0_WAIT);
        if (data_ready) begin
            fail_run("Reserved user slot 0 completed a read instead of staying silent");
        end
        read_n = periph_pkg::ACC_NONE;
        @(negedge clk);
    endtask

    initial begin
        op_t op;

        void'($urandom(32'h54ed));
        rst_n         = 1'b0;
        ui_in         = periph_pkg::byte_t'($urandom());
        addr          = '0;
        wdata         = '0;
        write_n       = periph_pkg::ACC_NONE;
        read_n        = periph_pkg::ACC_NONE;
        read_complete = 1'b0;
        // Slot 0 claims ready so the decoder has to ignore it
        for (int s = 0; s < `PERI_SLOTS; s++) begin
            user_rsp[s].data    = $urandom();
            user_rsp[s].ready   = 1'b1;
            user_rsp[s].pins    = periph_pkg::byte_t'($urandom());
            simple_rsp[s].data  = periph_pkg::byte_t'($urandom());
            simple_rsp[s].pins  = periph_pkg::byte_t'($urandom());
        end
        build_table();

        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_val("o_data_ready", 32'(data_ready), 32'h0);

        for (int i = 0; i < ops.size(); i++) begin
            op = ops[i];
            case (op.kind)
                OP_WR:     run_write(op);
                OP_RD:     run_read(op);
                OP_NORESP: run_noresp(op);
                default:   check_val("o_uo_out", 32'(uo_out), op.expected);
            endcase
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* periph_hub.sv */
/*
 * Top of the peripheral bus fabric. External peripherals attach through
 * the user and simple slot arrays; user slot 1 is the built-in GPIO.
 */
`timescale 1ns/1ps
`default_nettype none
`include "periph_defines.svh"

module periph_hub (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire periph_pkg::byte_t       i_ui_in,
    input  wire periph_pkg::addr_t       i_addr,
    input  wire periph_pkg::word_t       i_data,
    input  wire periph_pkg::access_e     i_data_write_n,
    input  wire periph_pkg::access_e     i_data_read_n,
    input  wire                          i_data_read_complete,
    input  wire periph_pkg::user_rsp_t   i_user_rsp [`PERI_SLOTS],
    input  wire periph_pkg::simple_rsp_t i_simple_rsp [`PERI_SLOTS],
    output periph_pkg::user_req_t        o_user_req [`PERI_SLOTS],
    output logic [`PERI_SLOTS-1:0]       o_simple_wr,
    output periph_pkg::word_t            o_data_out,
    output logic                         o_data_ready,
    output periph_pkg::byte_t            o_uo_out
);

    logic                  ready_q;
    logic                  slot_ready;
    periph_pkg::word_t     slot_data;
    periph_pkg::user_req_t gpio_req;
    periph_pkg::user_rsp_t gpio_rsp;
    periph_pkg::func_sel_t func_sel [`PERI_PINS];

    periph_read_resp u_read_resp (
        .i_clk                (clk),
        .i_rst_n              (rst_n),
        .i_read_n             (i_data_read_n),
        .i_write_n            (i_data_write_n),
        .i_slot_data          (slot_data),
        .i_slot_ready         (slot_ready),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .o_ready_q            (ready_q)
    );

    periph_bus_decode u_decode (
        .i_addr       (i_addr),
        .i_write_n    (i_data_write_n),
        .i_read_n     (i_data_read_n),
        .i_ready_q    (ready_q),
        .i_gpio_rsp   (gpio_rsp),
        .i_user_rsp   (i_user_rsp),
        .i_simple_rsp (i_simple_rsp),
        .o_user_req   (o_user_req),
        .o_simple_wr  (o_simple_wr),
        .o_gpio_req   (gpio_req),
        .o_slot_data  (slot_data),
        .o_slot_ready (slot_ready)
    );

    // GPIO only sees the offset within its slot and the low data byte
    gpio_regs u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_ofs      (i_addr[5:0]),
        .i_data     (i_data[7:0]),
        .i_req      (gpio_req),
        .i_ui_in    (i_ui_in),
        .o_rsp      (gpio_rsp),
        .o_func_sel (func_sel)
    );

    pin_func_mux u_pin_mux (
        .i_func_sel   (func_sel),
        .i_gpio_pins  (gpio_rsp.pins),
        .i_user_rsp   (i_user_rsp),
        .i_simple_rsp (i_simple_rsp),
        .o_uo_out     (o_uo_out)
    );

endmodule

`default_nettype wire

/* pin_func_mux.sv */
/*
 * Output PMOD mux. Each pin takes its own bit from the pins of the slot
 * named by that pin's function select.
 */
`timescale 1ns/1ps
`default_nettype none
`include "periph_defines.svh"

module pin_func_mux (
    input  wire periph_pkg::func_sel_t   i_func_sel [`PERI_PINS],
    input  wire periph_pkg::byte_t       i_gpio_pins,
    input  wire periph_pkg::user_rsp_t   i_user_rsp [`PERI_SLOTS],
    input  wire periph_pkg::simple_rsp_t i_simple_rsp [`PERI_SLOTS],
    output periph_pkg::byte_t            o_uo_out
);

    always_comb begin
        periph_pkg::func_sel_t sel;

        for (int p = 0; p < `PERI_PINS; p++) begin
            sel = i_func_sel[p];
            if (sel.is_simple) begin
                o_uo_out[p] = i_simple_rsp[sel.slot].pins[p];
            end else if (sel.slot == periph_pkg::slot_t'(0)) begin
                // Reserved slot drives nothing
                o_uo_out[p] = 1'b0;
            end else if (sel.slot == periph_pkg::slot_t'(`PERI_GPIO_SLOT)) begin
                o_uo_out[p] = i_gpio_pins[p];
            end else begin
                o_uo_out[p] = i_user_rsp[sel.slot].pins[p];
            end
        end
    end

endmodule

`default_nettype wire

/* gpio_regs.sv */
/*
 * Built-in GPIO slot: output register, input readback and the eight
 * pin function selects that feed the output pin mux.
 */
`timescale 1ns/1ps
`default_nettype none
`include "periph_defines.svh"

module gpio_regs (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire periph_pkg::reg_ofs_t  i_ofs,
    input  wire periph_pkg::byte_t     i_data,
    input  wire periph_pkg::user_req_t i_req,
    input  wire periph_pkg::byte_t     i_ui_in,
    output periph_pkg::user_rsp_t      o_rsp,
    output periph_pkg::func_sel_t      o_func_sel [`PERI_PINS]
);

    periph_pkg::byte_t gpio_out;
    periph_pkg::word_t rd_data;
    logic              wr_en;
    logic              sel_hit;
    logic [2:0]        sel_idx;

    // Request only arrives when this slot is addressed
    assign wr_en = (i_req.write_n != periph_pkg::ACC_NONE);

    // One function select word per pin from 0x20 to 0x3c
    assign sel_hit = i_ofs[5] && (i_ofs[1:0] == 2'b00);
    assign sel_idx = i_ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && i_ofs == `GPIO_OUT_OFS) begin
            gpio_out <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < `PERI_PINS; p++) begin
                // Low pins start on the UART, the rest on GPIO
                if (p < `PERI_UART_PINS) begin
                    o_func_sel[p] <= '{is_simple: 1'b0,
                                       slot: periph_pkg::slot_t'(`PERI_UART_SLOT)};
                end else begin
                    o_func_sel[p] <= '{is_simple: 1'b0,
                                       slot: periph_pkg::slot_t'(`PERI_GPIO_SLOT)};
                end
            end
        end else if (wr_en && sel_hit) begin
            o_func_sel[sel_idx] <= periph_pkg::func_sel_t'(i_data[4:0]);
        end
    end

    // Readback
    always_comb begin
        rd_data = '0;
        if (i_ofs == `GPIO_OUT_OFS) begin
            rd_data = {24'h0, gpio_out};
        end else if (i_ofs == `GPIO_IN_OFS) begin
            rd_data = {24'h0, i_ui_in};
        end else if (sel_hit) begin
            rd_data = {27'h0, o_func_sel[sel_idx]};
        end
    end

    assign o_rsp = '{data: rd_data, ready: 1'b1, pins: gpio_out};

endmodule

`default_nettype wire

/* periph_bus_decode.sv */
/*
 * Address decode for 16 user and 16 simple slots. Steers the core's
 * strobes to the selected slot and muxes back its data and ready.
 */
`timescale 1ns/1ps
`default_nettype none
`include "periph_defines.svh"

module periph_bus_decode (
    input  wire periph_pkg::addr_t       i_addr,
    input  wire periph_pkg::access_e     i_write_n,
    input  wire periph_pkg::access_e     i_read_n,
    input  wire                          i_ready_q,
    input  wire periph_pkg::user_rsp_t   i_gpio_rsp,
    input  wire periph_pkg::user_rsp_t   i_user_rsp [`PERI_SLOTS],
    input  wire periph_pkg::simple_rsp_t i_simple_rsp [`PERI_SLOTS],
    output periph_pkg::user_req_t        o_user_req [`PERI_SLOTS],
    output logic [`PERI_SLOTS-1:0]       o_simple_wr,
    output periph_pkg::user_req_t        o_gpio_req,
    output periph_pkg::word_t            o_slot_data,
    output logic                         o_slot_ready
);

    logic                is_simple;
    logic                wr_active;
    periph_pkg::slot_t   user_sel;
    periph_pkg::slot_t   simple_sel;
    periph_pkg::access_e read_masked;

    assign is_simple  = i_addr[`PERI_SIMPLE_BIT];
    assign user_sel   = i_addr[`PERI_USER_LSB +: 4];
    assign simple_sel = i_addr[`PERI_SIMPLE_LSB +: 4];
    assign wr_active  = (i_write_n != periph_pkg::ACC_NONE);

    // No second read reaches a slot while its result is still buffered
    assign read_masked = i_ready_q ? periph_pkg::ACC_NONE : i_read_n;

    always_comb begin
        for (int s = 0; s < `PERI_SLOTS; s++) begin
            o_user_req[s] = '{write_n: periph_pkg::ACC_NONE, read_n: periph_pkg::ACC_NONE};
            o_simple_wr[s] = 1'b0;
        end

        if (is_simple) begin
            o_simple_wr[simple_sel] = wr_active;
        end else begin
            o_user_req[user_sel] = '{write_n: i_write_n, read_n: read_masked};
        end
    end

    assign o_gpio_req = o_user_req[`PERI_GPIO_SLOT];

    // Response mux
    always_comb begin
        if (is_simple) begin
            // Byte-wide slots that are always ready
            o_slot_data  = {24'h0, i_simple_rsp[simple_sel].data};
            o_slot_ready = 1'b1;
        end else if (user_sel == periph_pkg::slot_t'(0)) begin
            // Reserved slot never answers
            o_slot_data  = '0;
            o_slot_ready = 1'b0;
        end else if (user_sel == periph_pkg::slot_t'(`PERI_GPIO_SLOT)) begin
            o_slot_data  = i_gpio_rsp.data;
            o_slot_ready = i_gpio_rsp.ready;
        end else begin
            o_slot_data  = i_user_rsp[user_sel].data;
            o_slot_ready = i_user_rsp[user_sel].ready;
        end
    end

endmodule

`default_nettype wire

/* periph_read_resp.sv */
/*
 * Registered read response towards the core. Captures the selected slot's
 * data once it is ready and holds it until the core ends the read.
 */
`timescale 1ns/1ps
`default_nettype none

module periph_read_resp (
    input  wire                  i_clk,
    input  wire                  i_rst_n,
    input  wire periph_pkg::access_e i_read_n,
    input  wire periph_pkg::access_e i_write_n,
    input  wire periph_pkg::word_t   i_slot_data,
    input  wire                  i_slot_ready,
    input  wire                  i_data_read_complete,
    output periph_pkg::word_t    o_data_out,
    output logic                 o_data_ready,
    output logic                 o_ready_q
);

    periph_pkg::rd_state_e state;
    periph_pkg::rd_state_e state_nxt;
    periph_pkg::word_t     data_q;
    logic                  read_req;
    logic                  capture;

    assign read_req = (i_read_n != periph_pkg::ACC_NONE);

    // Take new data only when nothing is held yet
    assign capture = (state == periph_pkg::RD_IDLE) && read_req && i_slot_ready;

    always_comb begin
        state_nxt = state;
        if (capture) begin
            state_nxt = periph_pkg::RD_HOLD;
        end else if (i_data_read_complete) begin
            state_nxt = periph_pkg::RD_IDLE;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state     <= periph_pkg::RD_IDLE;
            o_ready_q <= 1'b0;
        end else begin
            state     <= state_nxt;
            // Ready is registered to line up with the registered data
            o_ready_q <= read_req && i_slot_ready;
        end
    end

    always_ff @(posedge i_clk) begin
        if (capture) begin
            data_q <= i_slot_data;
        end
    end

    assign o_data_out = data_q;

    // Writes complete in the cycle they are issued
    assign o_data_ready = o_ready_q || (i_write_n != periph_pkg::ACC_NONE);

endmodule

`default_nettype wire

/* periph_pkg.sv */
/*
 * Shared types of the peripheral bus fabric. Modules refer to them
 * by scoped name.
 */
`default_nettype none

package periph_pkg;

    typedef logic [10:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  slot_t;
    typedef logic [5:0]  reg_ofs_t;

    // Size code of a core access where all ones means no access
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_e;

    // Source of one output pin
    typedef struct packed {
        logic  is_simple;
        slot_t slot;
    } func_sel_t;

    typedef struct packed {
        access_e write_n;
        access_e read_n;
    } user_req_t;

    typedef struct packed {
        word_t data;
        logic  ready;
        byte_t pins;
    } user_rsp_t;

    typedef struct packed {
        byte_t data;
        byte_t pins;
    } simple_rsp_t;

    typedef enum logic {
        RD_IDLE,
        RD_HOLD
    } rd_state_e;

endpackage

`default_nettype wire

/* periph_defines.svh */
/*
 * Constants of the peripheral bus fabric: address fields, slot counts,
 * GPIO register offsets and the pin routing applied at reset.
 */
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Slots per class and PMOD width
`define PERI_SLOTS 16
`define PERI_PINS 8

// Address bit 10 picks the simple class
`define PERI_SIMPLE_BIT 10

// Lowest address bit of the slot index in each class
`define PERI_USER_LSB 6
`define PERI_SIMPLE_LSB 4

// Fixed user slots
`define PERI_GPIO_SLOT 1
`define PERI_UART_SLOT 2

// Pins 0 up to this count start out on the UART slot
`define PERI_UART_PINS 2

// GPIO register offsets inside its 64-byte slot
`define GPIO_OUT_OFS 6'h00
`define GPIO_IN_OFS 6'h04

`endif
